//--- logic/rv_pkg.sv
package rv_pkg;

  localparam int XLEN   = 64;
  localparam int REG_AW = 5;
  localparam int NREGS  = 32;

  //////////////////////////////
  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_NONE, FWD_MEM, FWD_WB
  } fwd_sel_e;

  //////////////////////////////
  // instruction formats
  typedef struct packed {
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]       imm12;
    logic [REG_AW-1:0] rs1;     // upper immediate bits for lui
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]        imm_hi;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [4:0]        imm_lo;
    logic [6:0]        opcode;
  } s_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
  } rv_inst_u;

  //////////////////////////////
  // stage records
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    use_imm;
    logic    is_lui;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    ctrl_t             ctrl;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   imm;
  } id_ex_t;

  typedef struct packed {
    logic              reg_write;
    logic              mem_read;
    logic              mem_write;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   alu_result;
    logic [XLEN-1:0]   store_data;
  } ex_mem_t;

  typedef struct packed {
    logic              reg_write;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   data;
  } mem_wb_t;

  typedef struct packed {
    logic            we;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } dmem_req_t;

endpackage

//--- logic/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_stall,
  input  rv_pkg::rv_inst_u          i_imem_data,
  output logic [rv_pkg::XLEN-1:0]   o_pc,
  output rv_pkg::rv_inst_u          o_inst,
  output logic                      o_valid
);
  import rv_pkg::*;

  logic [XLEN-1:0] pc_next;

  assign pc_next = i_stall ? o_pc : o_pc + XLEN'(4);  // no branches, always sequential

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pc    <= RESET_PC;
      o_valid <= 1'b0;                 // decode sees a bubble first
    end else begin
      o_pc <= pc_next;
      if (!i_stall) begin
        o_valid <= 1'b1;
      end
    end
  end

  // fetch/decode word, held on load-use
  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      o_inst <= i_imem_data;
    end
  end

endmodule

//--- logic/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  rv_pkg::rv_inst_u            i_inst,
  input  logic                        i_valid,
  input  logic                        i_stall,
  input  rv_pkg::mem_wb_t             i_wb,
  output logic [rv_pkg::REG_AW-1:0]   o_rs1_addr,
  output logic [rv_pkg::REG_AW-1:0]   o_rs2_addr,
  output rv_pkg::id_ex_t              o_id_ex
);
  import rv_pkg::*;

  ctrl_t             ctrl;
  logic              use_rs1;
  logic              use_rs2;
  logic [XLEN-1:0]   imm;
  logic [XLEN-1:0]   regs [NREGS];
  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;
  ctrl_t             ctrl_q;
  logic [REG_AW-1:0] rs1_q;
  logic [REG_AW-1:0] rs2_q;
  logic [REG_AW-1:0] rd_q;
  logic [XLEN-1:0]   rs1_data_q;
  logic [XLEN-1:0]   rs2_data_q;
  logic [XLEN-1:0]   imm_q;

  //////////////////////////////
  // control and immediates
  always_comb begin
    ctrl    = '0;                      // unknown opcode retires as a bubble
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    imm     = '0;
    if (i_valid) begin
      case (i_inst.r.opcode)
        OPC_OP: begin
          ctrl.reg_write = 1'b1;
          use_rs1        = 1'b1;
          use_rs2        = 1'b1;
          case (i_inst.r.funct3)
            3'b000:  ctrl.alu_op = i_inst.r.funct7[5] ? ALU_SUB : ALU_ADD;
            3'b001:  ctrl.alu_op = ALU_SLL;
            3'b010:  ctrl.alu_op = ALU_SLT;
            3'b011:  ctrl.alu_op = ALU_SLTU;
            3'b100:  ctrl.alu_op = ALU_XOR;
            3'b101:  ctrl.alu_op = i_inst.r.funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  ctrl.alu_op = ALU_OR;
            default: ctrl.alu_op = ALU_AND;
          endcase
        end
        OPC_OP_IMM: begin
          ctrl.reg_write = 1'b1;
          ctrl.use_imm   = 1'b1;
          use_rs1        = 1'b1;
          imm            = {{(XLEN-12){i_inst.i.imm12[11]}}, i_inst.i.imm12};
          case (i_inst.i.funct3)
            3'b000:  ctrl.alu_op = ALU_ADD;
            3'b010:  ctrl.alu_op = ALU_SLT;
            3'b100:  ctrl.alu_op = ALU_XOR;
            3'b110:  ctrl.alu_op = ALU_OR;
            3'b111:  ctrl.alu_op = ALU_AND;
            default: begin             // shifts and sltiu not supported
              ctrl    = '0;
              use_rs1 = 1'b0;
            end
          endcase
        end
        OPC_LUI: begin
          ctrl.reg_write = 1'b1;
          ctrl.use_imm   = 1'b1;
          ctrl.is_lui    = 1'b1;
          imm = {{(XLEN-32){i_inst.i.imm12[11]}}, i_inst.i.imm12, i_inst.i.rs1,
                 i_inst.i.funct3, 12'b0};
        end
        OPC_LOAD: begin
          if (i_inst.i.funct3 == 3'b011) begin  // ld only
            ctrl.reg_write = 1'b1;
            ctrl.mem_read  = 1'b1;
            ctrl.use_imm   = 1'b1;
            use_rs1        = 1'b1;
            imm            = {{(XLEN-12){i_inst.i.imm12[11]}}, i_inst.i.imm12};
          end
        end
        OPC_STORE: begin
          if (i_inst.s.funct3 == 3'b011) begin  // sd only
            ctrl.mem_write = 1'b1;
            ctrl.use_imm   = 1'b1;
            use_rs1        = 1'b1;
            use_rs2        = 1'b1;
            imm = {{(XLEN-12){i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
          end
        end
        default: ;
      endcase
    end
  end

  // unused sources read as x0, so lui and bubbles never stall
  assign o_rs1_addr = use_rs1 ? i_inst.r.rs1 : '0;
  assign o_rs2_addr = use_rs2 ? i_inst.r.rs2 : '0;

  //////////////////////////////
  // register file
  function automatic logic [XLEN-1:0] rf_read(input logic [REG_AW-1:0] addr);
    logic [XLEN-1:0] val;
    if (addr == '0) begin
      val = '0;
    end else if (i_wb.reg_write && i_wb.rd == addr) begin
      val = i_wb.data;                 // same-cycle write bypass
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  always_comb begin
    rs1_data = rf_read(o_rs1_addr);
    rs2_data = rf_read(o_rs2_addr);
  end

  always_ff @(posedge i_clk) begin
    if (i_wb.reg_write && i_wb.rd != '0) begin
      regs[i_wb.rd] <= i_wb.data;
    end
  end

  //////////////////////////////
  // decode/execute register
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= i_stall ? '0 : ctrl;   // bubble on load-use
    end
  end

  always_ff @(posedge i_clk) begin
    rs1_q      <= o_rs1_addr;
    rs2_q      <= o_rs2_addr;
    rd_q       <= i_inst.r.rd;
    rs1_data_q <= rs1_data;
    rs2_data_q <= rs2_data;
    imm_q      <= imm;
  end

  assign o_id_ex = '{ctrl: ctrl_q, rs1: rs1_q, rs2: rs2_q, rd: rd_q,
                     rs1_data: rs1_data_q, rs2_data: rs2_data_q, imm: imm_q};

endmodule

//--- logic/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  rv_pkg::id_ex_t    i_id_ex,
  input  rv_pkg::fwd_sel_e  i_fwd_a,
  input  rv_pkg::fwd_sel_e  i_fwd_b,
  input  rv_pkg::mem_wb_t   i_wb,
  output rv_pkg::ex_mem_t   o_ex_mem
);
  import rv_pkg::*;

  localparam int SHW = $clog2(XLEN);

  logic [XLEN-1:0]   op_a;
  logic [XLEN-1:0]   rs2_fwd;
  logic [XLEN-1:0]   op_b;
  logic [SHW-1:0]    shamt;
  logic [XLEN-1:0]   result;
  logic              reg_write_q;
  logic              mem_read_q;
  logic              mem_write_q;
  logic [REG_AW-1:0] rd_q;
  logic [XLEN-1:0]   result_q;
  logic [XLEN-1:0]   store_q;

  function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                              input logic [XLEN-1:0] reg_val,
                                              input logic [XLEN-1:0] mem_val,
                                              input logic [XLEN-1:0] wb_val);
    logic [XLEN-1:0] val;
    case (sel)
      FWD_MEM: val = mem_val;
      FWD_WB:  val = wb_val;
      default: val = reg_val;
    endcase
    return val;
  endfunction

  //////////////////////////////
  // operand select
  assign op_a    = fwd_mux(i_fwd_a, i_id_ex.rs1_data, result_q, i_wb.data);
  assign rs2_fwd = fwd_mux(i_fwd_b, i_id_ex.rs2_data, result_q, i_wb.data);
  assign op_b    = i_id_ex.ctrl.use_imm ? i_id_ex.imm : rs2_fwd;
  assign shamt   = op_b[SHW-1:0];      // rv64 uses 6 shift bits

  //////////////////////////////
  // alu
  always_comb begin
    case (i_id_ex.ctrl.alu_op)
      ALU_SUB:  result = op_a - op_b;
      ALU_AND:  result = op_a & op_b;
      ALU_OR:   result = op_a | op_b;
      ALU_XOR:  result = op_a ^ op_b;
      ALU_SLL:  result = op_a << shamt;
      ALU_SRL:  result = op_a >> shamt;
      ALU_SRA:  result = $signed(op_a) >>> shamt;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, op_a < op_b};
      default:  result = op_a + op_b;  // add, also load/store address
    endcase
    if (i_id_ex.ctrl.is_lui) begin
      result = i_id_ex.imm;
    end
  end

  //////////////////////////////
  // execute/memory register
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      reg_write_q <= 1'b0;
      mem_read_q  <= 1'b0;
      mem_write_q <= 1'b0;
    end else begin
      reg_write_q <= i_id_ex.ctrl.reg_write;
      mem_read_q  <= i_id_ex.ctrl.mem_read;
      mem_write_q <= i_id_ex.ctrl.mem_write;
    end
  end

  always_ff @(posedge i_clk) begin
    rd_q     <= i_id_ex.rd;
    result_q <= result;
    store_q  <= rs2_fwd;               // forwarded store data
  end

  assign o_ex_mem = '{reg_write: reg_write_q, mem_read: mem_read_q, mem_write: mem_write_q,
                      rd: rd_q, alu_result: result_q, store_data: store_q};

endmodule

//--- logic/rv_memwb.sv
`timescale 1ns/1ps

module rv_memwb (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  rv_pkg::ex_mem_t           i_ex_mem,
  input  logic [rv_pkg::XLEN-1:0]   i_dmem_rdata,
  output rv_pkg::dmem_req_t         o_dmem,
  output rv_pkg::mem_wb_t           o_wb
);
  import rv_pkg::*;

  logic [XLEN-1:0]   wb_data;
  logic              reg_write_q;
  logic [REG_AW-1:0] rd_q;
  logic [XLEN-1:0]   data_q;

  //////////////////////////////
  // data memory request
  assign o_dmem = '{we:    i_ex_mem.mem_write,
                    addr:  i_ex_mem.alu_result,   // also the load address
                    wdata: i_ex_mem.store_data};

  assign wb_data = i_ex_mem.mem_read ? i_dmem_rdata : i_ex_mem.alu_result;

  //////////////////////////////
  // memory/writeback register
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      reg_write_q <= 1'b0;
    end else begin
      reg_write_q <= i_ex_mem.reg_write && (i_ex_mem.rd != '0);  // x0 never retires
    end
  end

  always_ff @(posedge i_clk) begin
    rd_q   <= i_ex_mem.rd;
    data_q <= wb_data;
  end

  assign o_wb = '{reg_write: reg_write_q, rd: rd_q, data: data_q};

endmodule

//--- logic/rv_hazard.sv
`timescale 1ns/1ps

module rv_hazard (
  input  logic [rv_pkg::REG_AW-1:0] i_rs1_d,
  input  logic [rv_pkg::REG_AW-1:0] i_rs2_d,
  input  rv_pkg::id_ex_t            i_ex,
  input  rv_pkg::ex_mem_t           i_mem,
  input  rv_pkg::mem_wb_t           i_wb,
  output rv_pkg::fwd_sel_e          o_fwd_a,
  output rv_pkg::fwd_sel_e          o_fwd_b,
  output logic                      o_stall
);
  import rv_pkg::*;

  function automatic fwd_sel_e pick_fwd(input logic [REG_AW-1:0] src,
                                        input ex_mem_t mem,
                                        input mem_wb_t wb);
    fwd_sel_e sel;
    sel = FWD_NONE;
    if (src != '0 && mem.reg_write && mem.rd == src) begin
      sel = FWD_MEM;                   // youngest result wins
    end else if (src != '0 && wb.reg_write && wb.rd == src) begin
      sel = FWD_WB;
    end
    return sel;
  endfunction

  assign o_fwd_a = pick_fwd(i_ex.rs1, i_mem, i_wb);
  assign o_fwd_b = pick_fwd(i_ex.rs2, i_mem, i_wb);

  // load in execute feeding the instruction in decode
  assign o_stall = i_ex.ctrl.mem_read && (i_ex.rd != '0) &&
                   (i_ex.rd == i_rs1_d || i_ex.rd == i_rs2_d);

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  output logic [rv_pkg::XLEN-1:0]   o_imem_addr,
  input  rv_pkg::rv_inst_u          i_imem_data,
  output rv_pkg::dmem_req_t         o_dmem,
  input  logic [rv_pkg::XLEN-1:0]   i_dmem_rdata,
  output rv_pkg::mem_wb_t           o_wb
);
  import rv_pkg::*;

  logic              stall;
  rv_inst_u          inst_fd;
  logic              valid_fd;
  logic [REG_AW-1:0] rs1_d;
  logic [REG_AW-1:0] rs2_d;
  id_ex_t            id_ex;
  ex_mem_t           ex_mem;
  fwd_sel_e          fwd_a;
  fwd_sel_e          fwd_b;

  //////////////////////////////
  // pipeline stages
  rv_fetch #(.RESET_PC(RESET_PC)) u_rv_fetch (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_stall     (stall),
    .i_imem_data (i_imem_data),
    .o_pc        (o_imem_addr),
    .o_inst      (inst_fd),
    .o_valid     (valid_fd)
  );

  rv_decode u_rv_decode (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_inst     (inst_fd),
    .i_valid    (valid_fd),
    .i_stall    (stall),
    .i_wb       (o_wb),               // register file write port
    .o_rs1_addr (rs1_d),
    .o_rs2_addr (rs2_d),
    .o_id_ex    (id_ex)
  );

  rv_execute u_rv_execute (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_id_ex  (id_ex),
    .i_fwd_a  (fwd_a),
    .i_fwd_b  (fwd_b),
    .i_wb     (o_wb),
    .o_ex_mem (ex_mem)
  );

  rv_memwb u_rv_memwb (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_ex_mem     (ex_mem),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem       (o_dmem),
    .o_wb         (o_wb)
  );

  rv_hazard u_rv_hazard (
    .i_rs1_d (rs1_d),
    .i_rs2_d (rs2_d),
    .i_ex    (id_ex),
    .i_mem   (ex_mem),
    .i_wb    (o_wb),
    .o_fwd_a (fwd_a),
    .o_fwd_b (fwd_b),
    .o_stall (stall)
  );

endmodule

//--- verification/rv_core_model.svh
`ifndef RV_CORE_MODEL_SVH
`define RV_CORE_MODEL_SVH

// initial data memory word from the full byte address
function automatic logic [63:0] dmem_fill(input int idx);
  logic [31:0] a;
  a = 32'(idx) << 3;
  return {a ^ 32'h3c5a_0f00, ~(a * 32'h9e37_79b9)};
endfunction

function automatic logic [63:0] sext12(input logic [11:0] v);
  return {{52{v[11]}}, v};
endfunction

// integer ops by funct3 with alt selecting sub and sra
function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [63:0] a, input logic [63:0] b);
  logic [63:0] res;
  case (f3)
    3'b000:  res = alt ? a - b : a + b;
    3'b001:  res = a << b[5:0];
    3'b010:  res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
    3'b011:  res = (a < b) ? 64'd1 : 64'd0;
    3'b100:  res = a ^ b;
    3'b101: begin
      if (alt) begin
        res = $signed(a) >>> b[5:0];   // sign bit fills from the left
      end else begin
        res = a >> b[5:0];
      end
    end
    3'b110:  res = a | b;
    default: res = a & b;
  endcase
  return res;
endfunction

// runs the whole program in order and fills the expected queues
function automatic void run_model();
  logic [63:0] xr [32];
  logic [63:0] mem_img [DMEM_WORDS];
  logic [31:0] w;
  logic [2:0]  f3;
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] res;
  logic [63:0] addr;
  logic        wr;
  mem_wb_t     ev;
  dmem_req_t   st;
  int          i;
  for (i = 0; i < 32; i++) begin
    xr[i] = '0;
  end
  for (i = 0; i < DMEM_WORDS; i++) begin
    mem_img[i] = dmem_fill(i);
  end
  for (i = 0; i < PROG_LEN; i++) begin
    w   = prog[i];
    f3  = w[14:12];
    a   = xr[w[19:15]];
    b   = xr[w[24:20]];
    wr  = 1'b0;
    res = '0;
    case (w[6:0])
      OPC_OP: begin
        wr  = 1'b1;
        res = alu_ref(f3, w[30], a, b);
      end
      OPC_OP_IMM: begin
        if (f3 != 3'b001 && f3 != 3'b011 && f3 != 3'b101) begin  // no shifts, no sltiu
          wr  = 1'b1;
          res = alu_ref(f3, 1'b0, a, sext12(w[31:20]));
        end
      end
      OPC_LUI: begin
        wr  = 1'b1;
        res = {{32{w[31]}}, w[31:12], 12'b0};
      end
      OPC_LOAD: begin
        if (f3 == 3'b011) begin
          addr = a + sext12(w[31:20]);
          wr   = 1'b1;
          res  = mem_img[addr[12:3]];
        end
      end
      OPC_STORE: begin
        if (f3 == 3'b011) begin
          addr                 = a + sext12({w[31:25], w[11:7]});
          mem_img[addr[12:3]]  = b;
          st.we    = 1'b1;
          st.addr  = addr;
          st.wdata = b;
          exp_st_q.push_back(st);
        end
      end
      default: ;                       // anything else is a bubble
    endcase
    if (wr && w[11:7] != 5'd0) begin
      xr[w[11:7]] = res;
      ev.reg_write = 1'b1;
      ev.rd        = w[11:7];
      ev.data      = res;
      exp_wb_q.push_back(ev);
    end
  end
endfunction

`endif

//--- verification/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;
  import rv_pkg::*;

  localparam int              N            = 200;
  localparam int              PROLOGUE     = 6;
  localparam int              PROG_LEN     = N + PROLOGUE;
  localparam int              RESET_CYCLES = 8;
  localparam int              CYCLE_LIMIT  = 2 * PROG_LEN + 60 + RESET_CYCLES;
  localparam int              DRAIN_CYCLES = 10;
  localparam int              IMEM_WORDS   = 1024;
  localparam int              DMEM_WORDS   = 1024;
  localparam logic [XLEN-1:0] RESET_PC     = 64'h200;

  logic            clk;
  logic            rst_n;
  logic [XLEN-1:0] imem_addr;
  rv_inst_u        imem_data;
  dmem_req_t       dmem_req;
  logic [XLEN-1:0] dmem_rdata;
  mem_wb_t         wb;

  logic [31:0]     imem [IMEM_WORDS];
  logic [63:0]     dmem [DMEM_WORDS];
  logic [31:0]     prog [PROG_LEN];
  mem_wb_t         exp_wb_q [$];
  dmem_req_t       exp_st_q [$];
  int              seed;
  int              cycles = 0;
  int              mismatches = 0;
  int              other_errors = 0;
  int              retired = 0;
  int              stored = 0;
  int              exp_wb_total;
  int              exp_st_total;

  `include "rv_core_model.svh"

  rv_core #(.RESET_PC(RESET_PC)) rv_core_i (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .o_imem_addr  (imem_addr),
    .i_imem_data  (imem_data),
    .o_dmem       (dmem_req),
    .i_dmem_rdata (dmem_rdata),
    .o_wb         (wb)
  );

  //////////////////////////////
  // clock and memories
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  assign imem_data  = imem[imem_addr[11:2]];
  assign dmem_rdata = dmem[dmem_req.addr[12:3]];   // combinational read

  always @(posedge clk) begin
    if (dmem_req.we === 1'b1) begin
      dmem[dmem_req.addr[12:3]] <= dmem_req.wdata;
    end
  end

  //////////////////////////////
  // program generation
  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] random_inst();
    int unsigned kind;
    int unsigned pick;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] off;
    logic [31:0] w;
    kind = $unsigned($random(seed)) % 16;
    pick = $unsigned($random(seed));
    rd   = 5'(pick % 6);               // x0..x5, dense dependencies
    rs1  = 5'((pick >> 4) % 6);
    rs2  = 5'((pick >> 8) % 6);
    f3   = pick[14:12];
    off  = {5'b0, pick[23:20], 3'b0};  // 16 doublewords above x10
    if (kind < 5 || kind == 15) begin
      w = {(f3 == 3'b000 || f3 == 3'b101) && pick[15] ? 7'h20 : 7'h00,
           rs2, rs1, f3, rd, OPC_OP};
    end else if (kind < 9) begin
      case ((pick >> 12) % 5)
        0:       f3 = 3'b000;
        1:       f3 = 3'b010;
        2:       f3 = 3'b100;
        3:       f3 = 3'b110;
        default: f3 = 3'b111;
      endcase
      w = enc_i(pick[31:20], rs1, f3, rd, OPC_OP_IMM);
    end else if (kind == 9) begin
      w = {pick[31:12], rd, OPC_LUI};
    end else if (kind < 12) begin
      w = enc_i(off, 5'd10, 3'b011, rd, OPC_LOAD);
    end else if (kind < 14) begin
      w = enc_s(off, rs2, 5'd10, 3'b011);
    end else begin
      case ((pick >> 12) % 4)          // opcodes the core does not decode
        0:       w = {pick[31:7], 7'b1100011};
        1:       w = {pick[31:7], 7'b1101111};
        2:       w = {pick[31:7], 7'b1110011};
        default: w = {pick[31:7], 7'b0011011};
      endcase
    end
    return w;
  endfunction

  task automatic build_program();
    int i;
    prog[0] = {20'h00001, 5'd10, OPC_LUI};  // x10 = 0x1000, data base
    for (i = 1; i < PROLOGUE; i++) begin
      prog[i] = enc_i(12'($random(seed)), 5'd0, 3'b000, 5'(i), OPC_OP_IMM);
    end
    for (i = PROLOGUE; i < PROG_LEN; i++) begin
      prog[i] = random_inst();
    end
    for (i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = 32'h0000_0013;         // nop
    end
    for (i = 0; i < PROG_LEN; i++) begin
      imem[int'(RESET_PC >> 2) + i] = prog[i];
    end
    for (i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = dmem_fill(i);
    end
  endtask

  //////////////////////////////
  // comparison
  task automatic check_retire(input mem_wb_t got);
    mem_wb_t exp;
    if (got.rd == '0) begin
      $display("register write to x0 retired at %0t", $time);
      other_errors++;
    end else if (exp_wb_q.size() == 0) begin
      $display("unexpected register write to x%0d at %0t", got.rd, $time);
      other_errors++;
      retired++;
    end else begin
      exp = exp_wb_q.pop_front();
      retired++;
      if (got.rd !== exp.rd) begin
        $display("mismatch at %0t: o_wb.rd got %0d expected %0d", $time, got.rd, exp.rd);
        mismatches++;
      end
      if (got.data !== exp.data) begin
        $display("mismatch at %0t: o_wb.data got %h expected %h", $time, got.data, exp.data);
        mismatches++;
      end
    end
  endtask

  task automatic check_store(input dmem_req_t got);
    dmem_req_t exp;
    stored++;
    if (exp_st_q.size() == 0) begin
      $display("unexpected store to %h at %0t", got.addr, $time);
      other_errors++;
    end else begin
      exp = exp_st_q.pop_front();
      if (got.addr !== exp.addr) begin
        $display("mismatch at %0t: o_dmem.addr got %h expected %h", $time, got.addr, exp.addr);
        mismatches++;
      end
      if (got.wdata !== exp.wdata) begin
        $display("mismatch at %0t: o_dmem.wdata got %h expected %h",
                 $time, got.wdata, exp.wdata);
        mismatches++;
      end
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      if (wb.reg_write === 1'b1) begin
        check_retire(wb);
      end
      if (dmem_req.we === 1'b1) begin
        check_store(dmem_req);
      end
    end
  end

  //////////////////////////////
  // main sequence
  initial begin
    seed  = 32'h4fd0_05ca;
    rst_n = 1'b0;
    build_program();
    run_model();
    exp_wb_total = exp_wb_q.size();
    exp_st_total = exp_st_q.size();
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      if (wb.reg_write !== 1'b0 || dmem_req.we !== 1'b0) begin
        $display("write strobe active during reset at %0t", $time);
        other_errors++;
      end
    end
    @(posedge clk);
    #2 rst_n = 1'b1;
    @(negedge clk);
    if (imem_addr !== RESET_PC) begin
      $display("mismatch at %0t: o_imem_addr got %h expected %h", $time, imem_addr, RESET_PC);
      mismatches++;
    end
    while ((exp_wb_q.size() != 0 || exp_st_q.size() != 0) && cycles < CYCLE_LIMIT) begin
      @(posedge clk);
    end
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d writes and %0d stores never arrived",
               cycles, exp_wb_q.size(), exp_st_q.size());
      other_errors++;
    end else begin
      repeat (DRAIN_CYCLES) @(posedge clk);  // catch stray events
    end
    if (retired != exp_wb_total || stored != exp_st_total) begin
      $display("event count differs from the model");
      other_errors++;
    end
    $display("errors: %0d mismatches, %0d other; retires %0d of %0d, stores %0d of %0d",
             mismatches, other_errors, retired, exp_wb_total, stored, exp_st_total);
    if (mismatches == 0 && other_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- rv_core.f
+incdir+verification
logic/rv_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_memwb.sv
logic/rv_hazard.sv
logic/rv_core.sv
verification/rv_core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f rv_core.f \
  --top-module rv_core_tb -o rv_core_sim
./obj_dir/rv_core_sim > sim.log
cat sim.log
if grep -qx "test passed" sim.log; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi
